// ==== design/rvPkg.sv ====
`default_nettype none

package rvPkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] regIdx_t;

	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_SLT, ALU_SLL, ALU_SRL, ALU_SRA
	} aluOp_t;

	typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} immKind_t;

	typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_LINK} wbSel_t;

	typedef enum logic [3:0] {
		IDLE, FETCH, FETCH_WAIT, DECODE, REG_READ, EXECUTE,
		MEM_ACCESS, MEM_WAIT, WRITE_BACK, BRANCH, HALT
	} fsmState_t;

	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_IMM    = 7'b0010011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	localparam logic [2:0] F3_ADD = 3'b000; // also sub, addi, jalr
	localparam logic [2:0] F3_SLL = 3'b001;
	localparam logic [2:0] F3_SLT = 3'b010;
	localparam logic [2:0] F3_SR  = 3'b101; // srl, srli and srai
	localparam logic [2:0] F3_AND = 3'b111;
	localparam logic [2:0] F3_LW  = 3'b010;
	localparam logic [2:0] F3_SW  = 3'b010;
	localparam logic [2:0] F3_BEQ = 3'b000;
	localparam logic [2:0] F3_BNE = 3'b001;
	localparam logic [2:0] F3_BLT = 3'b100;
	localparam logic [2:0] F3_BGE = 3'b101;

endpackage

`default_nettype wire

// ==== design/controlFsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlFsm
	import rvPkg::*;
(
	input logic clk,
	input logic rst,
	input logic run,
	input word_t instr,
	input logic eq,
	input logic lt,
	input logic memGnt,
	input logic memRvalid,
	output logic pcWr,
	output logic pcFromAlu,
	output logic irWr,
	output logic regsWr,
	output logic aluOutWr,
	output logic mdrWr,
	output logic regWr,
	output logic aluSrcImm,
	output logic aluSrcPc,
	output logic fetchReq,
	output logic dataReq,
	output logic dataWe,
	output logic halted,
	output aluOp_t aluOp,
	output immKind_t immKind,
	output wbSel_t wbSel
);
	fsmState_t state, nextState;
	logic [6:0] opcode;
	logic [2:0] funct3, brFunct3;
	logic isLoad, isStore, isBranch, isJump, taken;
	aluOp_t dAluOp;
	immKind_t dImmKind;
	wbSel_t dWbSel;
	logic dSrcImm, dSrcPc, dLoad, dStore, dBranch, dJump, dValid;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];

	// instruction classification, sampled only in DECODE
	always_comb begin
		dAluOp = ALU_ADD;
		dImmKind = IMM_I;
		dWbSel = WB_ALU;
		dSrcImm = 1'b1;
		dSrcPc = 1'b0;
		dLoad = 1'b0;
		dStore = 1'b0;
		dBranch = 1'b0;
		dJump = 1'b0;
		dValid = 1'b1;
		case (opcode)
			OPC_OP: begin
				dSrcImm = 1'b0;
				case (funct3)
					F3_ADD: dAluOp = instr[30] ? ALU_SUB : ALU_ADD;
					F3_AND: dAluOp = ALU_AND;
					F3_SLT: dAluOp = ALU_SLT;
					default: dValid = 1'b0;
				endcase
			end
			OPC_IMM: begin
				case (funct3)
					F3_ADD: dAluOp = ALU_ADD;
					F3_SLT: dAluOp = ALU_SLT;
					F3_SLL: dAluOp = ALU_SLL;
					F3_SR: dAluOp = instr[30] ? ALU_SRA : ALU_SRL;
					default: dValid = 1'b0;
				endcase
			end
			OPC_LUI: dImmKind = IMM_U; // x0 + imm
			OPC_LOAD: begin
				dLoad = 1'b1;
				dWbSel = WB_MEM;
				dValid = (funct3 == F3_LW);
			end
			OPC_STORE: begin
				dStore = 1'b1;
				dImmKind = IMM_S;
				dValid = (funct3 == F3_SW);
			end
			OPC_BRANCH: begin
				dBranch = 1'b1;
				dImmKind = IMM_B;
				dSrcPc = 1'b1; // target from instruction pc
				dValid = (funct3 == F3_BEQ) || (funct3 == F3_BNE) ||
					(funct3 == F3_BLT) || (funct3 == F3_BGE);
			end
			OPC_JAL: begin
				dJump = 1'b1;
				dImmKind = IMM_J;
				dSrcPc = 1'b1;
				dWbSel = WB_LINK;
			end
			OPC_JALR: begin
				dJump = 1'b1;
				dWbSel = WB_LINK;
			end
			default: dValid = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= IDLE;
			aluOp <= ALU_ADD;
			immKind <= IMM_I;
			wbSel <= WB_ALU;
			aluSrcImm <= 1'b0;
			aluSrcPc <= 1'b0;
			isLoad <= 1'b0;
			isStore <= 1'b0;
			isBranch <= 1'b0;
			isJump <= 1'b0;
			brFunct3 <= '0;
		end else begin
			state <= nextState;
			if (state == DECODE) begin
				aluOp <= dAluOp;
				immKind <= dImmKind;
				wbSel <= dWbSel;
				aluSrcImm <= dSrcImm;
				aluSrcPc <= dSrcPc;
				isLoad <= dLoad;
				isStore <= dStore;
				isBranch <= dBranch;
				isJump <= dJump;
				brFunct3 <= funct3;
			end
		end
	end

	always_comb begin
		case (brFunct3)
			F3_BEQ: taken = eq;
			F3_BNE: taken = !eq;
			F3_BLT: taken = lt;
			F3_BGE: taken = !lt;
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		nextState = state;
		pcWr = 1'b0;
		pcFromAlu = 1'b0;
		irWr = 1'b0;
		regsWr = 1'b0;
		aluOutWr = 1'b0;
		mdrWr = 1'b0;
		regWr = 1'b0;
		fetchReq = 1'b0;
		dataReq = 1'b0;
		dataWe = 1'b0;
		case (state)
			IDLE: if (run) nextState = FETCH;
			FETCH: begin
				fetchReq = 1'b1;
				if (memGnt) nextState = FETCH_WAIT;
			end
			FETCH_WAIT: begin
				if (memRvalid) begin
					irWr = 1'b1;
					pcWr = 1'b1; // pc + 4
					nextState = DECODE;
				end
			end
			DECODE: begin
				if (opcode == OPC_SYSTEM) nextState = HALT; // ebreak
				else if (dValid) nextState = REG_READ;
				else nextState = FETCH; // unknown, skipped
			end
			REG_READ: begin
				regsWr = 1'b1;
				nextState = EXECUTE;
			end
			EXECUTE: begin
				aluOutWr = 1'b1;
				if (isLoad || isStore) nextState = MEM_ACCESS;
				else if (isBranch) nextState = BRANCH;
				else nextState = WRITE_BACK;
			end
			MEM_ACCESS: begin
				dataReq = 1'b1;
				dataWe = isStore;
				if (memGnt) nextState = isStore ? FETCH : MEM_WAIT;
			end
			MEM_WAIT: begin
				if (memRvalid) begin
					mdrWr = 1'b1;
					nextState = WRITE_BACK;
				end
			end
			WRITE_BACK: begin
				regWr = 1'b1;
				pcWr = isJump; // link uses the old pc
				pcFromAlu = isJump;
				nextState = FETCH;
			end
			BRANCH: begin
				pcWr = taken;
				pcFromAlu = 1'b1;
				nextState = FETCH;
			end
			HALT: nextState = HALT;
			default: nextState = IDLE;
		endcase
	end

	assign halted = (state == HALT);

endmodule

`default_nettype wire

// ==== design/datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module datapath
	import rvPkg::*;
#(
	parameter word_t ResetPc = '0
) (
	input logic clk,
	input logic rst,
	input logic pcWr,
	input logic pcFromAlu,
	input logic irWr,
	input logic regsWr,
	input logic aluOutWr,
	input logic mdrWr,
	input logic regWr,
	input logic aluSrcImm,
	input logic aluSrcPc,
	input aluOp_t aluOp,
	input immKind_t immKind,
	input wbSel_t wbSel,
	input word_t memRdata,
	output word_t instr,
	output logic eq,
	output logic lt,
	output word_t fetchAddr,
	output word_t dataAddr,
	output word_t dataWdata
);
	word_t pc;
	word_t pcInstr; // address of the instruction in ir
	word_t ir;
	word_t a;
	word_t b;
	word_t aluOut;
	word_t mdr;
	word_t rf [32];
	word_t imm;
	word_t opA;
	word_t opB;
	word_t aluResult;
	word_t wbData;
	regIdx_t rs1;
	regIdx_t rs2;
	regIdx_t rd;
	logic [32:0] diff;

	assign instr = ir;
	assign rs1 = (immKind == IMM_U) ? '0 : ir[19:15]; // lui carries imm in rs1 field
	assign rs2 = ir[24:20];
	assign rd = ir[11:7];

	always_comb begin
		case (immKind)
			IMM_I: imm = {{20{ir[31]}}, ir[31:20]};
			IMM_S: imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
			IMM_B: imm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
			IMM_U: imm = {ir[31:12], 12'b0};
			IMM_J: imm = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
			default: imm = '0;
		endcase
	end

	assign opA = aluSrcPc ? pcInstr : a;
	assign opB = aluSrcImm ? imm : b;

	always_comb begin
		case (aluOp)
			ALU_ADD: aluResult = opA + opB;
			ALU_SUB: aluResult = opA - opB;
			ALU_AND: aluResult = opA & opB;
			ALU_SLT: aluResult = {31'b0, $signed(opA) < $signed(opB)};
			ALU_SLL: aluResult = opA << opB[4:0];
			ALU_SRL: aluResult = opA >> opB[4:0];
			ALU_SRA: aluResult = $signed(opA) >>> opB[4:0];
			default: aluResult = '0;
		endcase
	end

	// sign-extended subtract cannot overflow in 33 bits
	assign diff = {a[31], a} - {b[31], b};
	assign eq = (diff == '0);
	assign lt = diff[32];

	always_comb begin
		case (wbSel)
			WB_MEM: wbData = mdr;
			WB_LINK: wbData = pc; // already advanced past the jump
			default: wbData = aluOut;
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			pc <= ResetPc;
		end else if (pcWr) begin
			pc <= pcFromAlu ? {aluOut[31:1], 1'b0} : pc + 32'd4;
		end
	end

	always_ff @(posedge clk) begin
		if (irWr) begin
			ir <= memRdata;
			pcInstr <= pc;
		end
		if (regsWr) begin
			a <= (rs1 == '0) ? '0 : rf[rs1]; // x0 reads zero
			b <= (rs2 == '0) ? '0 : rf[rs2];
		end
		if (aluOutWr) aluOut <= aluResult;
		if (mdrWr) mdr <= memRdata;
		if (regWr) rf[rd] <= wbData;
	end

	assign fetchAddr = pc;
	assign dataAddr = aluOut;
	assign dataWdata = b;

endmodule

`default_nettype wire

// ==== design/memArbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module memArbiter
	import rvPkg::*;
#(
	parameter int MemAddrBits = 8
) (
	input logic clk,
	input logic rst,
	input logic fetchReq,
	input logic fetchWe,
	input logic [MemAddrBits-1:0] fetchAddr,
	input word_t fetchWdata,
	output logic fetchGnt,
	output logic fetchRvalid,
	output word_t fetchRdata,
	input logic dataReq,
	input logic dataWe,
	input logic [MemAddrBits-1:0] dataAddr,
	input word_t dataWdata,
	output logic dataGnt,
	output logic dataRvalid,
	output word_t dataRdata,
	input logic hostReq,
	input logic hostWe,
	input logic [MemAddrBits-1:0] hostAddr,
	input word_t hostWdata,
	output logic hostGnt,
	output logic hostRvalid,
	output word_t hostRdata,
	output logic ramEn,
	output logic ramWe,
	output logic [MemAddrBits-1:0] ramAddr,
	output word_t ramWdata,
	input word_t ramRdata
);
	// data beats fetch beats host
	assign dataGnt = dataReq;
	assign fetchGnt = fetchReq && !dataReq;
	assign hostGnt = hostReq && !dataReq && !fetchReq;
	assign ramEn = dataGnt || fetchGnt || hostGnt;

	always_comb begin
		ramWe = hostWe;
		ramAddr = hostAddr;
		ramWdata = hostWdata;
		if (dataGnt) begin
			ramWe = dataWe;
			ramAddr = dataAddr;
			ramWdata = dataWdata;
		end else if (fetchGnt) begin
			ramWe = fetchWe;
			ramAddr = fetchAddr;
			ramWdata = fetchWdata;
		end
	end

	// owner of the read in flight
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			fetchRvalid <= 1'b0;
			dataRvalid <= 1'b0;
			hostRvalid <= 1'b0;
		end else begin
			fetchRvalid <= fetchGnt && !fetchWe;
			dataRvalid <= dataGnt && !dataWe;
			hostRvalid <= hostGnt && !hostWe;
		end
	end

	assign fetchRdata = fetchRvalid ? ramRdata : '0;
	assign dataRdata = dataRvalid ? ramRdata : '0;
	assign hostRdata = hostRvalid ? ramRdata : '0;

endmodule

`default_nettype wire

// ==== design/unifiedRam.sv ====
`timescale 1ns/1ps
`default_nettype none

module unifiedRam
	import rvPkg::*;
#(
	parameter int MemAddrBits = 8
) (
	input logic clk,
	input logic ramEn,
	input logic ramWe,
	input logic [MemAddrBits-1:0] ramAddr,
	input word_t ramWdata,
	output word_t ramRdata
);
	word_t mem [2**MemAddrBits];

	always_ff @(posedge clk) begin
		if (ramEn) begin
			if (ramWe) mem[ramAddr] <= ramWdata;
			else ramRdata <= mem[ramAddr]; // valid next cycle
		end
	end

endmodule

`default_nettype wire

// ==== design/hostAxiPort.sv ====
`timescale 1ns/1ps
`default_nettype none

module hostAxiPort
	import rvPkg::*;
#(
	parameter int MemAddrBits = 8
) (
	input logic clk,
	input logic rst,
	input logic awvalid,
	output logic awready,
	input word_t awaddr,
	input logic wvalid,
	output logic wready,
	input word_t wdata,
	output logic bvalid,
	input logic bready,
	input logic arvalid,
	output logic arready,
	input word_t araddr,
	output logic rvalid,
	input logic rready,
	output word_t rdata,
	output logic memReq,
	output logic memWe,
	output logic [MemAddrBits-1:0] memAddr,
	output word_t memWdata,
	input logic memGnt,
	input logic memRvalid,
	input word_t memRdata
);
	logic busy, wrReq, rdReq, rdHold;
	word_t rdataReg;

	assign busy = bvalid || rvalid; // one transaction outstanding at most
	assign wrReq = awvalid && wvalid && !busy;
	assign rdReq = arvalid && !busy && !wrReq;

	assign memReq = wrReq || rdReq;
	assign memWe = wrReq;
	assign memAddr = wrReq ? awaddr[MemAddrBits+1:2] : araddr[MemAddrBits+1:2];
	assign memWdata = wdata;

	assign awready = wrReq && memGnt;
	assign wready = wrReq && memGnt;
	assign arready = rdReq && memGnt;

	// data goes out the cycle it returns, held only if not taken
	assign rvalid = rdHold || memRvalid;
	assign rdata = rdHold ? rdataReg : memRdata;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			bvalid <= 1'b0;
			rdHold <= 1'b0;
		end else begin
			if (awready) bvalid <= 1'b1;
			else if (bready) bvalid <= 1'b0;
			rdHold <= rvalid && !rready;
		end
	end

	always_ff @(posedge clk) begin
		if (memRvalid) rdataReg <= memRdata;
	end

endmodule

`default_nettype wire

// ==== design/rvSystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvSystem
	import rvPkg::*;
#(
	parameter int MemAddrBits = 8,
	parameter word_t ResetPc = '0
) (
	input logic clk,
	input logic rst,
	input logic run,
	input logic awvalid,
	output logic awready,
	input word_t awaddr,
	input logic wvalid,
	output logic wready,
	input word_t wdata,
	output logic bvalid,
	input logic bready,
	input logic arvalid,
	output logic arready,
	input word_t araddr,
	output logic rvalid,
	input logic rready,
	output word_t rdata,
	output logic halted
);
	logic pcWr, pcFromAlu, irWr, regsWr, aluOutWr, mdrWr, regWr, aluSrcImm, aluSrcPc;
	aluOp_t aluOp;
	immKind_t immKind;
	wbSel_t wbSel;
	logic eq, lt;
	word_t instr, fetchAddr, dataAddr, dataWdata;
	logic fetchReq, dataReq, dataWe;
	logic fetchGnt, fetchRvalid, dataGnt, dataRvalid;
	word_t fetchRdata, dataRdata;
	logic hostReq, hostWe, hostGnt, hostRvalid;
	logic [MemAddrBits-1:0] hostAddr, ramAddr;
	word_t hostWdata, hostRdata, ramWdata, ramRdata;
	logic ramEn, ramWe;

	// fetch and data never overlap, so their returns merge onto one core bus
	controlFsm i_controlFsm (
		.clk(clk), .rst(rst), .run(run), .instr(instr), .eq(eq), .lt(lt),
		.memGnt(fetchGnt | dataGnt), .memRvalid(fetchRvalid | dataRvalid),
		.pcWr(pcWr), .pcFromAlu(pcFromAlu), .irWr(irWr), .regsWr(regsWr),
		.aluOutWr(aluOutWr), .mdrWr(mdrWr), .regWr(regWr), .aluSrcImm(aluSrcImm),
		.aluSrcPc(aluSrcPc), .fetchReq(fetchReq), .dataReq(dataReq), .dataWe(dataWe),
		.halted(halted), .aluOp(aluOp), .immKind(immKind), .wbSel(wbSel)
	);

	datapath #(.ResetPc(ResetPc)) i_datapath (
		.clk(clk), .rst(rst), .pcWr(pcWr), .pcFromAlu(pcFromAlu), .irWr(irWr),
		.regsWr(regsWr), .aluOutWr(aluOutWr), .mdrWr(mdrWr), .regWr(regWr),
		.aluSrcImm(aluSrcImm), .aluSrcPc(aluSrcPc), .aluOp(aluOp), .immKind(immKind),
		.wbSel(wbSel), .memRdata(fetchRdata | dataRdata), .instr(instr), .eq(eq), .lt(lt),
		.fetchAddr(fetchAddr), .dataAddr(dataAddr), .dataWdata(dataWdata)
	);

	memArbiter #(.MemAddrBits(MemAddrBits)) i_memArbiter (
		.clk(clk), .rst(rst),
		.fetchReq(fetchReq), .fetchWe(1'b0), .fetchAddr(fetchAddr[MemAddrBits+1:2]),
		.fetchWdata('0), .fetchGnt(fetchGnt), .fetchRvalid(fetchRvalid),
		.fetchRdata(fetchRdata),
		.dataReq(dataReq), .dataWe(dataWe), .dataAddr(dataAddr[MemAddrBits+1:2]),
		.dataWdata(dataWdata), .dataGnt(dataGnt), .dataRvalid(dataRvalid),
		.dataRdata(dataRdata),
		.hostReq(hostReq), .hostWe(hostWe), .hostAddr(hostAddr), .hostWdata(hostWdata),
		.hostGnt(hostGnt), .hostRvalid(hostRvalid), .hostRdata(hostRdata),
		.ramEn(ramEn), .ramWe(ramWe), .ramAddr(ramAddr), .ramWdata(ramWdata),
		.ramRdata(ramRdata)
	);

	unifiedRam #(.MemAddrBits(MemAddrBits)) i_unifiedRam (
		.clk(clk), .ramEn(ramEn), .ramWe(ramWe), .ramAddr(ramAddr),
		.ramWdata(ramWdata), .ramRdata(ramRdata)
	);

	hostAxiPort #(.MemAddrBits(MemAddrBits)) i_hostAxiPort (
		.clk(clk), .rst(rst),
		.awvalid(awvalid), .awready(awready), .awaddr(awaddr),
		.wvalid(wvalid), .wready(wready), .wdata(wdata),
		.bvalid(bvalid), .bready(bready),
		.arvalid(arvalid), .arready(arready), .araddr(araddr),
		.rvalid(rvalid), .rready(rready), .rdata(rdata),
		.memReq(hostReq), .memWe(hostWe), .memAddr(hostAddr), .memWdata(hostWdata),
		.memGnt(hostGnt), .memRvalid(hostRvalid), .memRdata(hostRdata)
	);

endmodule

`default_nettype wire

// ==== tests/rvSystem_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvSystem_asserts
	import rvPkg::*;
(
	input logic clk,
	input logic rst,
	input logic fetchReq,
	input logic fetchGnt,
	input logic dataGnt,
	input logic hostReq,
	input logic hostGnt,
	input logic bvalid,
	input logic bready,
	input logic rvalid,
	input logic rready,
	input word_t rdata,
	input logic halted
);
	assert property (@(posedge clk) disable iff (!rst) $onehot0({fetchGnt, dataGnt, hostGnt}))
		else $error("more than one grant in a cycle");
	assert property (@(posedge clk) disable iff (!rst) fetchReq && !fetchGnt |=> fetchReq)
		else $error("fetch request dropped before grant");
	assert property (@(posedge clk) disable iff (!rst) hostReq && !hostGnt |=> hostReq)
		else $error("host request dropped before grant");
	assert property (@(posedge clk) disable iff (!rst) bvalid && !bready |=> bvalid)
		else $error("bvalid dropped before bready");
	assert property (@(posedge clk) disable iff (!rst)
		rvalid && !rready |=> rvalid && $stable(rdata))
		else $error("read response changed before rready");
	assert property (@(posedge clk) !rst |-> !halted)
		else $error("halted high during reset");

endmodule

bind rvSystem rvSystem_asserts u_asserts (
	.clk(clk), .rst(rst), .fetchReq(fetchReq), .fetchGnt(fetchGnt),
	.dataGnt(dataGnt), .hostReq(hostReq), .hostGnt(hostGnt), .bvalid(bvalid), .bready(bready),
	.rvalid(rvalid), .rready(rready), .rdata(rdata), .halted(halted)
);

`default_nettype wire

// ==== tests/tb_rvSystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rvSystem
	import rvPkg::*;
;
	localparam int HalfPeriod = 10;
	localparam int SampleDelay = 8; // just before the rising edge
	localparam int WaitLimit = 2000;
	localparam int HaltLimit = 20000;
	localparam word_t Ebreak = 32'h0010_0073;

	logic clk, rst, run;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready, halted;
	word_t awaddr, wdata, araddr, rdata;
	word_t prog [$];
	logic [31:0] lfsr = 32'h883d_c8cf;
	int errors = 0;
	int testsRun = 0;
	int testsFailed = 0;
	string testName;

	rvSystem i_dut (
		.clk(clk), .rst(rst), .run(run),
		.awvalid(awvalid), .awready(awready), .awaddr(awaddr),
		.wvalid(wvalid), .wready(wready), .wdata(wdata),
		.bvalid(bvalid), .bready(bready),
		.arvalid(arvalid), .arready(arready), .araddr(araddr),
		.rvalid(rvalid), .rready(rready), .rdata(rdata), .halted(halted)
	);

	always #HalfPeriod clk = !clk;

	function automatic logic stepLfsr();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]; // taps 32 22 2 1
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic word_t randWord();
		word_t w;
		w = '0;
		for (int i = 0; i < 32; i++) w = {w[30:0], stepLfsr()};
		return w;
	endfunction

	function automatic word_t rType(logic [6:0] f7, regIdx_t rs2, regIdx_t rs1,
			logic [2:0] f3, regIdx_t rd);
		return {f7, rs2, rs1, f3, rd, OPC_OP};
	endfunction

	function automatic word_t iType(logic [11:0] imm, regIdx_t rs1, logic [2:0] f3,
			regIdx_t rd, logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic word_t sType(logic [11:0] imm, regIdx_t rs2, regIdx_t rs1);
		return {imm[11:5], rs2, rs1, F3_SW, imm[4:0], OPC_STORE};
	endfunction

	function automatic word_t bType(logic [2:0] f3, regIdx_t rs1, regIdx_t rs2,
			logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
	endfunction

	function automatic word_t jType(regIdx_t rd, logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
	endfunction

	// branch outcome by the RV32I rules
	function automatic logic branchTaken(logic [2:0] f3, word_t a, word_t b);
		case (f3)
			F3_BEQ: return a == b;
			F3_BNE: return a != b;
			F3_BLT: return $signed(a) < $signed(b);
			default: return $signed(a) >= $signed(b);
		endcase
	endfunction

	task automatic finishRun();
		$display("tests run %0d, tests failed %0d, errors %0d", testsRun, testsFailed, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	endtask

	task automatic giveUp(string what);
		errors++;
		$display("timeout: %s", what);
		finishRun();
	endtask

	task automatic checkWord(string name, word_t exp, word_t act);
		assert (act === exp) else begin
			$display("ERROR %s, %s: expected %h, actual %h", testName, name, exp, act);
			errors++;
		end
	endtask

	task automatic endTest(int errorsBefore);
		testsRun++;
		if (errors != errorsBefore) testsFailed++;
		$display("test %s: %0d errors", testName, errors - errorsBefore);
	endtask

	task automatic resetDut();
		@(negedge clk);
		rst = 1'b0;
		run = 1'b0;
		repeat (2) @(negedge clk);
		rst = 1'b1;
	endtask

	// hold > 0 keeps bready low for that many cycles once bvalid is up
	task automatic axiWrite(word_t addr, word_t data, int hold);
		int n;
		logic ok;
		@(negedge clk);
		awvalid = 1'b1;
		wvalid = 1'b1;
		awaddr = addr;
		wdata = data;
		bready = (hold == 0);
		n = 0;
		ok = 1'b0;
		while (!ok && n < WaitLimit) begin
			#SampleDelay ok = awready && wready;
			@(negedge clk);
			n++;
		end
		awvalid = 1'b0;
		wvalid = 1'b0;
		if (!ok) giveUp("host write was never accepted");
		n = 0;
		ok = 1'b0;
		while (!ok && n < WaitLimit) begin
			#SampleDelay ok = bvalid;
			@(negedge clk);
			n++;
		end
		if (!ok) giveUp("write response never arrived");
		repeat (hold) begin
			#SampleDelay checkWord("write held bvalid", 32'd1, {31'b0, bvalid});
			@(negedge clk);
		end
		bready = 1'b1;
	endtask

	// hold > 0 keeps rready low for that many cycles once rvalid is up
	task automatic axiRead(word_t addr, int hold, output word_t data);
		int n;
		logic ok;
		@(negedge clk);
		arvalid = 1'b1;
		araddr = addr;
		rready = (hold == 0);
		n = 0;
		ok = 1'b0;
		while (!ok && n < WaitLimit) begin
			#SampleDelay ok = arready;
			@(negedge clk);
			n++;
		end
		arvalid = 1'b0;
		if (!ok) giveUp("host read address was never accepted");
		n = 0;
		ok = 1'b0;
		while (!ok && n < WaitLimit) begin
			#SampleDelay ok = rvalid;
			data = rdata;
			@(negedge clk);
			n++;
		end
		if (!ok) giveUp("read data never arrived");
		repeat (hold) begin
			#SampleDelay checkWord("read held rvalid", 32'd1, {31'b0, rvalid});
			checkWord("read held rdata", data, rdata);
			@(negedge clk);
		end
		rready = 1'b1;
	endtask

	task automatic loadProgram();
		foreach (prog[i]) axiWrite(i * 4, prog[i], 0);
		prog.delete();
	endtask

	task automatic runToHalt();
		int n;
		@(negedge clk);
		run = 1'b1;
		n = 0;
		while (!halted && n < HaltLimit) begin
			@(negedge clk);
			n++;
		end
		run = 1'b0;
		if (!halted) giveUp("core never halted");
	endtask

	task automatic testHostRoundTrip();
		int e0;
		word_t v [4];
		word_t got;
		e0 = errors;
		testName = "host round trip";
		foreach (v[i]) v[i] = randWord();
		axiWrite(32'h300, v[0], 0);
		axiWrite(32'h304, v[1], 2);
		axiWrite(32'h3fc, v[2], 0);
		axiWrite(32'h1308, v[3], 0); // wraps onto 0x308
		axiRead(32'h300, 0, got);
		checkWord("host 0x300", v[0], got);
		axiRead(32'h304, 3, got);
		checkWord("host 0x304 held", v[1], got);
		axiRead(32'h3fc, 0, got);
		checkWord("host 0x3fc", v[2], got);
		axiRead(32'h308, 0, got);
		checkWord("host wrap", v[3], got);
		endTest(e0);
	endtask

	task automatic testArith();
		int e0;
		word_t x [12];
		word_t got;
		e0 = errors;
		testName = "arithmetic and shifts";
		resetDut();
		axiWrite(32'h200, 32'hffff_ffff, 0); // x0 slot must be cleared
		prog.push_back(iType(12'd100, 0, F3_ADD, 1, OPC_IMM));
		prog.push_back(iType(-12'sd7, 0, F3_ADD, 2, OPC_IMM));
		prog.push_back(rType(7'h00, 2, 1, F3_ADD, 3));
		prog.push_back(rType(7'h20, 2, 1, F3_ADD, 4));
		prog.push_back(rType(7'h00, 2, 1, F3_AND, 5));
		prog.push_back(rType(7'h00, 1, 2, F3_SLT, 6));
		prog.push_back(iType(12'd50, 1, F3_SLT, 7, OPC_IMM));
		prog.push_back({20'habcde, 5'd8, OPC_LUI});
		prog.push_back(iType(12'd4, 8, F3_SLL, 9, OPC_IMM));
		prog.push_back(iType(12'd8, 8, F3_SR, 10, OPC_IMM));
		prog.push_back(iType(12'h408, 8, F3_SR, 11, OPC_IMM)); // srai
		prog.push_back(iType(12'd55, 0, F3_ADD, 0, OPC_IMM));
		for (int i = 0; i < 12; i++) prog.push_back(sType(12'h200 + 4 * i, i, 0));
		prog.push_back(Ebreak);
		loadProgram();
		runToHalt();
		x[0] = 0;
		x[1] = 100;
		x[2] = -7;
		x[3] = x[1] + x[2];
		x[4] = x[1] - x[2];
		x[5] = x[1] & x[2];
		x[6] = 1;
		x[7] = 0;
		x[8] = 32'habcde000;
		x[9] = x[8] << 4;
		x[10] = x[8] >> 8;
		x[11] = $signed(x[8]) >>> 8;
		for (int i = 0; i < 12; i++) begin
			axiRead(32'h200 + 4 * i, 0, got);
			checkWord($sformatf("arith x%0d", i), x[i], got);
		end
		endTest(e0);
	endtask

	task automatic testLoadStore();
		int e0;
		word_t v [4];
		word_t got;
		e0 = errors;
		testName = "loads and stores";
		resetDut();
		foreach (v[i]) begin
			v[i] = randWord();
			axiWrite(32'h280 + 4 * i, v[i], 0);
		end
		prog.push_back(iType(12'h280, 0, F3_ADD, 1, OPC_IMM));
		prog.push_back(iType(12'd0, 1, F3_LW, 2, OPC_LOAD));
		prog.push_back(iType(12'd4, 1, F3_LW, 3, OPC_LOAD));
		prog.push_back(iType(12'd12, 1, F3_LW, 4, OPC_LOAD));
		prog.push_back(iType(12'd64, 1, F3_ADD, 5, OPC_IMM)); // base 0x2c0
		prog.push_back(sType(12'd8, 2, 5));
		prog.push_back(sType(12'd0, 3, 5));
		prog.push_back(sType(12'd4, 4, 5));
		prog.push_back(Ebreak);
		loadProgram();
		runToHalt();
		axiRead(32'h2c8, 0, got);
		checkWord("lw/sw 0x2c8", v[0], got);
		axiRead(32'h2c0, 0, got);
		checkWord("lw/sw 0x2c0", v[1], got);
		axiRead(32'h2c4, 0, got);
		checkWord("lw/sw 0x2c4", v[3], got);
		endTest(e0);
	endtask

	task automatic testControlFlow();
		int e0;
		int p;
		word_t regVal [4];
		logic [2:0] f3 [8];
		regIdx_t ra [8];
		regIdx_t rb [8];
		word_t got;
		e0 = errors;
		testName = "control flow";
		resetDut();
		regVal = '{0, 5, 5, -3};
		f3 = '{F3_BEQ, F3_BEQ, F3_BNE, F3_BNE, F3_BLT, F3_BLT, F3_BGE, F3_BGE};
		ra = '{1, 1, 1, 1, 3, 1, 1, 3};
		rb = '{2, 3, 3, 2, 1, 3, 3, 1};
		for (int i = 0; i < 11; i++) axiWrite(32'h380 + 4 * i, 0, 0);
		prog.push_back(iType(12'd5, 0, F3_ADD, 1, OPC_IMM));
		prog.push_back(iType(12'd5, 0, F3_ADD, 2, OPC_IMM));
		prog.push_back(iType(-12'sd3, 0, F3_ADD, 3, OPC_IMM));
		prog.push_back(iType(12'h7a, 0, F3_ADD, 20, OPC_IMM)); // taken marker
		prog.push_back(iType(12'h4e, 0, F3_ADD, 21, OPC_IMM)); // fall-through marker
		for (int i = 0; i < 8; i++) begin
			prog.push_back(bType(f3[i], ra[i], rb[i], 13'd12));
			prog.push_back(sType(12'h380 + 4 * i, 21, 0));
			prog.push_back(jType(0, 21'd8));
			prog.push_back(sType(12'h380 + 4 * i, 20, 0));
		end
		p = prog.size() * 4;
		prog.push_back(jType(5, 21'd8));
		prog.push_back(Ebreak); // skipped by jal
		prog.push_back(sType(12'h3a0, 5, 0));
		prog.push_back(iType(12'(p + 24), 0, F3_ADD, 6, OPC_IMM));
		prog.push_back(iType(12'd1, 6, F3_ADD, 7, OPC_JALR)); // odd target, low bit dropped
		prog.push_back(Ebreak);
		prog.push_back(sType(12'h3a4, 7, 0));
		prog.push_back(jType(8, 21'd8)); // link is off by one if the pc kept bit 0
		prog.push_back(Ebreak);
		prog.push_back(sType(12'h3a8, 8, 0));
		prog.push_back(Ebreak);
		loadProgram();
		runToHalt();
		for (int i = 0; i < 8; i++) begin
			axiRead(32'h380 + 4 * i, 0, got);
			checkWord($sformatf("branch case %0d", i),
				branchTaken(f3[i], regVal[ra[i]], regVal[rb[i]]) ? 32'h7a : 32'h4e, got);
		end
		axiRead(32'h3a0, 0, got);
		checkWord("jal link", p + 4, got);
		axiRead(32'h3a4, 0, got);
		checkWord("jalr link", p + 20, got);
		axiRead(32'h3a8, 0, got);
		checkWord("jalr target", p + 32, got);
		endTest(e0);
	endtask

	task automatic testRandomOps();
		int e0;
		word_t a [4];
		word_t b [4];
		word_t got;
		e0 = errors;
		testName = "random operands";
		resetDut();
		for (int k = 0; k < 4; k++) begin
			a[k] = randWord();
			b[k] = randWord();
			axiWrite(32'h300 + 8 * k, a[k], 0);
			axiWrite(32'h304 + 8 * k, b[k], 0);
			prog.push_back(iType(12'h300 + 8 * k, 0, F3_LW, 1, OPC_LOAD));
			prog.push_back(iType(12'h304 + 8 * k, 0, F3_LW, 2, OPC_LOAD));
			prog.push_back(rType(7'h00, 2, 1, F3_ADD, 3));
			prog.push_back(rType(7'h20, 2, 1, F3_ADD, 4));
			prog.push_back(rType(7'h00, 2, 1, F3_SLT, 5));
			prog.push_back(sType(12'h340 + 12 * k, 3, 0));
			prog.push_back(sType(12'h344 + 12 * k, 4, 0));
			prog.push_back(sType(12'h348 + 12 * k, 5, 0));
		end
		prog.push_back(Ebreak);
		loadProgram();
		runToHalt();
		for (int k = 0; k < 4; k++) begin
			axiRead(32'h340 + 12 * k, 0, got);
			checkWord($sformatf("rand sum %0d", k), a[k] + b[k], got);
			axiRead(32'h344 + 12 * k, 0, got);
			checkWord($sformatf("rand diff %0d", k), a[k] - b[k], got);
			axiRead(32'h348 + 12 * k, 0, got);
			checkWord($sformatf("rand slt %0d", k), {31'b0, $signed(a[k]) < $signed(b[k])}, got);
		end
		endTest(e0);
	endtask

	task automatic testHaltContention();
		int e0;
		word_t probe;
		word_t got;
		word_t pcAfterEbreak;
		e0 = errors;
		testName = "halt and contention";
		resetDut();
		probe = randWord();
		axiWrite(32'h3f0, probe, 0);
		axiWrite(32'h3e0, 32'h1111_1111, 0);
		prog.push_back(iType(12'd40, 0, F3_ADD, 1, OPC_IMM));
		prog.push_back(iType(-12'sd1, 1, F3_ADD, 1, OPC_IMM)); // loop body
		prog.push_back(bType(F3_BNE, 1, 0, -13'sd4));
		pcAfterEbreak = prog.size() * 4 + 4; // fetch already moved past it
		prog.push_back(Ebreak);
		prog.push_back(iType(12'h123, 0, F3_ADD, 9, OPC_IMM));
		prog.push_back(sType(12'h3e0, 9, 0)); // must never run
		loadProgram();
		@(negedge clk);
		run = 1'b1;
		for (int i = 0; i < 4; i++) begin
			axiRead(32'h3f0, i % 2, got);
			checkWord("read during run", probe, got);
		end
		checkWord("still running after host reads", 32'd0, {31'b0, halted});
		runToHalt();
		checkWord("pc at halt", pcAfterEbreak, i_dut.i_datapath.pc);
		repeat (5) @(negedge clk);
		checkWord("pc after halt", pcAfterEbreak, i_dut.i_datapath.pc);
		axiRead(32'h3e0, 0, got);
		checkWord("word past ebreak", 32'h1111_1111, got);
		endTest(e0);
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b0;
		run = 1'b0;
		awvalid = 1'b0;
		awaddr = '0;
		wvalid = 1'b0;
		wdata = '0;
		bready = 1'b1;
		arvalid = 1'b0;
		araddr = '0;
		rready = 1'b1;
		resetDut();
		testHostRoundTrip();
		testArith();
		testLoadStore();
		testControlFlow();
		testRandomOps();
		testHaltContention();
		finishRun();
	end

endmodule

`default_nettype wire

// ==== rvSystem.f ====
design/rvPkg.sv
design/controlFsm.sv
design/datapath.sv
design/memArbiter.sv
design/unifiedRam.sv
design/hostAxiPort.sv
design/rvSystem.sv
tests/rvSystem_asserts.sv
tests/tb_rvSystem.sv
